/* design/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STALL_W    = 6;
    localparam int STALL_IF   = 1;
    localparam int STALL_ID   = 2;

    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31; // link register

    // opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b00_0000;
    localparam logic [5:0] OP_REGIMM  = 6'b00_0001;
    localparam logic [5:0] OP_J       = 6'b00_0010;
    localparam logic [5:0] OP_JAL     = 6'b00_0011;
    localparam logic [5:0] OP_BEQ     = 6'b00_0100;
    localparam logic [5:0] OP_BNE     = 6'b00_0101;
    localparam logic [5:0] OP_BLEZ    = 6'b00_0110;
    localparam logic [5:0] OP_BGTZ    = 6'b00_0111;
    localparam logic [5:0] OP_ADDI    = 6'b00_1000;
    localparam logic [5:0] OP_ADDIU   = 6'b00_1001;
    localparam logic [5:0] OP_SLTI    = 6'b00_1010;
    localparam logic [5:0] OP_SLTIU   = 6'b00_1011;
    localparam logic [5:0] OP_ANDI    = 6'b00_1100;
    localparam logic [5:0] OP_ORI     = 6'b00_1101;
    localparam logic [5:0] OP_XORI    = 6'b00_1110;
    localparam logic [5:0] OP_LUI     = 6'b00_1111;
    localparam logic [5:0] OP_LW      = 6'b10_0011;
    localparam logic [5:0] OP_SW      = 6'b10_1011;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_ADD  = 6'b10_0000;
    localparam logic [5:0] FN_ADDU = 6'b10_0001;
    localparam logic [5:0] FN_SUB  = 6'b10_0010;
    localparam logic [5:0] FN_SUBU = 6'b10_0011;
    localparam logic [5:0] FN_AND  = 6'b10_0100;
    localparam logic [5:0] FN_OR   = 6'b10_0101;
    localparam logic [5:0] FN_XOR  = 6'b10_0110;
    localparam logic [5:0] FN_NOR  = 6'b10_0111;
    localparam logic [5:0] FN_SLT  = 6'b10_1010;
    localparam logic [5:0] FN_SLTU = 6'b10_1011;
    localparam logic [5:0] FN_JR   = 6'b00_1000;
    localparam logic [5:0] FN_JALR = 6'b00_1001;
    localparam logic [5:0] FN_SLL  = 6'b00_0000;
    localparam logic [5:0] FN_SRL  = 6'b00_0010;
    localparam logic [5:0] FN_SRA  = 6'b00_0011;
    localparam logic [5:0] FN_SLLV = 6'b00_0100;
    localparam logic [5:0] FN_SRLV = 6'b00_0110;
    localparam logic [5:0] FN_SRAV = 6'b00_0111;

    // rt field selectors under OP_REGIMM
    localparam logic [4:0] RT_BLTZ   = 5'b0_0000;
    localparam logic [4:0] RT_BGEZ   = 5'b0_0001;
    localparam logic [4:0] RT_BLTZAL = 5'b1_0000;
    localparam logic [4:0] RT_BGEZAL = 5'b1_0001;

    typedef struct packed {
        logic            ce;
        logic [XLEN-1:0] pc;
    } if_to_id_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } reg_write_t;

    typedef struct packed {
        logic op_add, op_sub, op_slt, op_sltu;
        logic op_and, op_nor, op_or, op_xor;
        logic op_sll, op_srl, op_sra, op_lui;
    } alu_op_t;

    typedef struct packed {
        logic sa;
        logic pc;
        logic rs; // bit 0
    } src1_sel_t;

    typedef struct packed {
        logic zimm;
        logic eight;
        logic simm;
        logic rt; // bit 0
    } src2_sel_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_J, BR_JR
    } br_kind_t;

    typedef struct packed {
        alu_op_t               alu_op;
        src1_sel_t             src1_sel;
        src2_sel_t             src2_sel;
        logic                  mem_en;
        logic [3:0]            mem_wen;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        br_kind_t              br_kind;
        logic                  uses_rs;
        logic                  uses_rt;
    } dec_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        alu_op_t               alu_op;
        src1_sel_t             src1_sel;
        src2_sel_t             src2_sel;
        logic                  mem_en;
        logic [3:0]            mem_wen;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        logic [XLEN-1:0]       rdata1;
        logic [XLEN-1:0]       rdata2;
    } id_to_ex_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_t;

endpackage

`default_nettype wire

/* design/if_id_reg.sv */
`default_nettype none

module if_id_reg import id_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [STALL_W-1:0] stall,
    input  if_to_id_t          if_to_id,
    input  logic [XLEN-1:0]    inst_sram_rdata,
    output if_to_id_t          id_bus,
    output logic [XLEN-1:0]    inst
);

    logic            hold;     // replaying buffered word
    logic [XLEN-1:0] inst_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_bus <= '0;
        end else if (stall[STALL_IF] && !stall[STALL_ID]) begin
            id_bus <= '0; // bubble into decode
        end else if (!stall[STALL_IF]) begin
            id_bus <= if_to_id;
        end
    end

    // sram data only lives one cycle, so grab it as the stall begins
    always_ff @(posedge clk) begin
        if (rst) begin
            hold <= 1'b0;
        end else begin
            hold <= stall[STALL_IF];
        end
    end

    always_ff @(posedge clk) begin
        if (stall[STALL_IF] && !hold) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign inst = !id_bus.ce ? '0 : (hold ? inst_buf : inst_sram_rdata); // all zero is a nop

endmodule

`default_nettype wire

/* design/regfile.sv */
`default_nettype none

module regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  reg_write_t            wr
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // same-cycle writes reach decode through the wb forward bus
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  logic [XLEN-1:0] inst,
    input  logic            ce,
    output dec_ctrl_t       ctrl
);

    logic [5:0] opcode, func;
    logic [4:0] rt_f, rd_f;
    logic       special, regimm;
    logic inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_nor, inst_or, inst_xor, inst_jr, inst_jalr;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addi, inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori;
    logic inst_xori, inst_lui, inst_lw, inst_sw, inst_j, inst_jal;
    logic inst_beq, inst_bne, inst_bgtz, inst_blez;
    logic inst_bltz, inst_bgez, inst_bltzal, inst_bgezal;
    logic r_alu, shift_sa, shift_v, imm_alu, link;
    br_kind_t kind;

    assign opcode  = inst[31:26];
    assign rt_f    = inst[20:16];
    assign rd_f    = inst[15:11];
    assign func    = inst[5:0];
    assign special = (opcode == OP_SPECIAL);
    assign regimm  = (opcode == OP_REGIMM);

    assign inst_add    = special && func == FN_ADD;
    assign inst_addu   = special && func == FN_ADDU;
    assign inst_sub    = special && func == FN_SUB;
    assign inst_subu   = special && func == FN_SUBU;
    assign inst_slt    = special && func == FN_SLT;
    assign inst_sltu   = special && func == FN_SLTU;
    assign inst_and    = special && func == FN_AND;
    assign inst_nor    = special && func == FN_NOR;
    assign inst_or     = special && func == FN_OR;
    assign inst_xor    = special && func == FN_XOR;
    assign inst_jr     = special && func == FN_JR;
    assign inst_jalr   = special && func == FN_JALR;
    assign inst_sll    = special && func == FN_SLL;
    assign inst_srl    = special && func == FN_SRL;
    assign inst_sra    = special && func == FN_SRA;
    assign inst_sllv   = special && func == FN_SLLV;
    assign inst_srlv   = special && func == FN_SRLV;
    assign inst_srav   = special && func == FN_SRAV;
    assign inst_addi   = opcode == OP_ADDI;
    assign inst_addiu  = opcode == OP_ADDIU;
    assign inst_slti   = opcode == OP_SLTI;
    assign inst_sltiu  = opcode == OP_SLTIU;
    assign inst_andi   = opcode == OP_ANDI;
    assign inst_ori    = opcode == OP_ORI;
    assign inst_xori   = opcode == OP_XORI;
    assign inst_lui    = opcode == OP_LUI;
    assign inst_lw     = opcode == OP_LW;
    assign inst_sw     = opcode == OP_SW;
    assign inst_j      = opcode == OP_J;
    assign inst_jal    = opcode == OP_JAL;
    assign inst_beq    = opcode == OP_BEQ;
    assign inst_bne    = opcode == OP_BNE;
    assign inst_bgtz   = opcode == OP_BGTZ && rt_f == '0;
    assign inst_blez   = opcode == OP_BLEZ && rt_f == '0;
    assign inst_bltz   = regimm && rt_f == RT_BLTZ;
    assign inst_bgez   = regimm && rt_f == RT_BGEZ;
    assign inst_bltzal = regimm && rt_f == RT_BLTZAL;
    assign inst_bgezal = regimm && rt_f == RT_BGEZAL;

    // instruction groups
    assign r_alu    = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
                    | inst_and | inst_nor | inst_or | inst_xor;
    assign shift_sa = inst_sll | inst_srl | inst_sra;
    assign shift_v  = inst_sllv | inst_srlv | inst_srav;
    assign imm_alu  = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                    | inst_xori | inst_lui;
    assign link     = inst_jal | inst_jalr | inst_bgezal | inst_bltzal; // pc+8 into rf

    always_comb begin
        kind = BR_NONE;
        if (inst_beq)                     kind = BR_BEQ;
        else if (inst_bne)                kind = BR_BNE;
        else if (inst_bgez | inst_bgezal) kind = BR_BGEZ;
        else if (inst_bltz | inst_bltzal) kind = BR_BLTZ;
        else if (inst_bgtz)               kind = BR_BGTZ;
        else if (inst_blez)               kind = BR_BLEZ;
        else if (inst_j | inst_jal)       kind = BR_J;
        else if (inst_jr | inst_jalr)     kind = BR_JR;
    end

    always_comb begin
        ctrl.alu_op.op_add  = inst_addi | inst_addiu | inst_add | inst_addu | inst_lw | inst_sw
                            | link;
        ctrl.alu_op.op_sub  = inst_sub | inst_subu;
        ctrl.alu_op.op_slt  = inst_slt | inst_slti;
        ctrl.alu_op.op_sltu = inst_sltu | inst_sltiu;
        ctrl.alu_op.op_and  = inst_and | inst_andi;
        ctrl.alu_op.op_nor  = inst_nor;
        ctrl.alu_op.op_or   = inst_or | inst_ori;
        ctrl.alu_op.op_xor  = inst_xor | inst_xori;
        ctrl.alu_op.op_sll  = inst_sll | inst_sllv;
        ctrl.alu_op.op_srl  = inst_srl | inst_srlv;
        ctrl.alu_op.op_sra  = inst_sra | inst_srav;
        ctrl.alu_op.op_lui  = inst_lui;

        ctrl.src1_sel.rs    = r_alu | shift_v | (imm_alu & ~inst_lui) | inst_lw | inst_sw;
        ctrl.src1_sel.pc    = link;
        ctrl.src1_sel.sa    = shift_sa;
        ctrl.src2_sel.rt    = r_alu | shift_sa | shift_v;
        ctrl.src2_sel.simm  = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_lui
                            | inst_lw | inst_sw;
        ctrl.src2_sel.eight = link;
        ctrl.src2_sel.zimm  = inst_andi | inst_ori | inst_xori;

        // side effects only for a live instruction
        ctrl.mem_en   = ce & (inst_lw | inst_sw);
        ctrl.mem_wen  = (ce & inst_sw) ? 4'b1111 : 4'b0000;
        ctrl.rf_we    = ce & (r_alu | shift_sa | shift_v | imm_alu | inst_lw | link);
        ctrl.rf_waddr = (r_alu | shift_sa | shift_v | inst_jalr) ? rd_f
                      : (imm_alu | inst_lw)                     ? rt_f
                      : (inst_jal | inst_bgezal | inst_bltzal)  ? RA_REG
                      : '0;
        ctrl.br_kind  = ce ? kind : BR_NONE;
        ctrl.uses_rs  = ce & (ctrl.src1_sel.rs | inst_jr | inst_jalr | inst_beq | inst_bne
                            | inst_bgtz | inst_blez | regimm);
        ctrl.uses_rt  = ce & (ctrl.src2_sel.rt | inst_sw | inst_beq | inst_bne); // sw data too
    end

endmodule

`default_nettype wire

/* design/operand_forward.sv */
`default_nettype none

module operand_forward import id_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs,
    input  logic [REG_ADDR_W-1:0] rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  logic [XLEN-1:0]       rf_rdata1,
    input  logic [XLEN-1:0]       rf_rdata2,
    input  reg_write_t            ex_fw,
    input  reg_write_t            mem_fw,
    input  reg_write_t            wb_fw,
    input  logic                  ex_is_load,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    output logic                  stallreq
);

    // r0 never matches since it has to stay zero
    function automatic logic hit(input reg_write_t fw, input logic [REG_ADDR_W-1:0] addr);
        return fw.we && fw.waddr == addr && addr != '0;
    endfunction

    // youngest producer wins
    assign rdata1 = hit(ex_fw, rs)  ? ex_fw.wdata
                  : hit(mem_fw, rs) ? mem_fw.wdata
                  : hit(wb_fw, rs)  ? wb_fw.wdata
                  : rf_rdata1;

    assign rdata2 = hit(ex_fw, rt)  ? ex_fw.wdata
                  : hit(mem_fw, rt) ? mem_fw.wdata
                  : hit(wb_fw, rt)  ? wb_fw.wdata
                  : rf_rdata2;

    // load data only exists after mem, so ex forwarding can't cover it
    assign stallreq = ex_is_load && ex_fw.waddr != '0
                   && ((uses_rs && ex_fw.waddr == rs) || (uses_rt && ex_fw.waddr == rt));

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`default_nettype none

module branch_unit import id_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] inst,
    input  br_kind_t        br_kind,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    output br_t             br
);

    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] br_off;     // sign-extended word offset
    logic [XLEN-1:0] jmp_target;
    logic            rs_eq_rt, rs_neg, rs_zero;

    assign pc_plus_4  = pc + 32'd4;
    assign br_off     = {{14{inst[15]}}, inst[15:0], 2'b00};
    assign jmp_target = {pc_plus_4[XLEN-1:XLEN-4], inst[25:0], 2'b00}; // stays in 256MB region

    assign rs_eq_rt = (rdata1 == rdata2);
    assign rs_neg   = rdata1[XLEN-1];
    assign rs_zero  = (rdata1 == '0);

    always_comb begin
        br.taken  = 1'b0;
        br.target = pc_plus_4 + br_off; // relative target by default
        case (br_kind)
            BR_BEQ:  br.taken = rs_eq_rt;
            BR_BNE:  br.taken = !rs_eq_rt;
            BR_BGEZ: br.taken = !rs_neg;
            BR_BLTZ: br.taken = rs_neg;
            BR_BGTZ: br.taken = !rs_neg && !rs_zero;
            BR_BLEZ: br.taken = rs_neg || rs_zero;
            BR_J: begin
                br.taken  = 1'b1;
                br.target = jmp_target;
            end
            BR_JR: begin
                br.taken  = 1'b1;
                br.target = rdata1;
            end
            default: br.taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/id_stage.sv */
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [STALL_W-1:0] stall,
    input  if_to_id_t          if_to_id,
    input  logic [XLEN-1:0]    inst_sram_rdata,
    input  reg_write_t         wb_to_rf,
    input  reg_write_t         ex_fw,
    input  reg_write_t         mem_fw,
    input  reg_write_t         wb_fw,
    input  logic               ex_is_load,
    output id_to_ex_t          id_to_ex,
    output br_t                br,
    output logic               stallreq
);

    if_to_id_t             id_bus;
    logic [XLEN-1:0]       inst;
    dec_ctrl_t             ctrl;
    logic [REG_ADDR_W-1:0] rs, rt;
    logic [XLEN-1:0]       rf_rdata1, rf_rdata2;
    logic [XLEN-1:0]       rdata1, rdata2; // after forwarding

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    if_id_reg u_if_id_reg (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .if_to_id        (if_to_id),
        .inst_sram_rdata (inst_sram_rdata),
        .id_bus          (id_bus),
        .inst            (inst)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_to_rf)
    );

    inst_decoder u_inst_decoder (
        .inst (inst),
        .ce   (id_bus.ce),
        .ctrl (ctrl)
    );

    operand_forward u_operand_forward (
        .rs         (rs),
        .rt         (rt),
        .uses_rs    (ctrl.uses_rs),
        .uses_rt    (ctrl.uses_rt),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_fw      (ex_fw),
        .mem_fw     (mem_fw),
        .wb_fw      (wb_fw),
        .ex_is_load (ex_is_load),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .stallreq   (stallreq)
    );

    branch_unit u_branch_unit (
        .pc      (id_bus.pc),
        .inst    (inst),
        .br_kind (ctrl.br_kind),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .br      (br)
    );

    assign id_to_ex = '{
        pc:       id_bus.pc,
        inst:     inst,
        alu_op:   ctrl.alu_op,
        src1_sel: ctrl.src1_sel,
        src2_sel: ctrl.src2_sel,
        mem_en:   ctrl.mem_en,
        mem_wen:  ctrl.mem_wen,
        rf_we:    ctrl.rf_we,
        rf_waddr: ctrl.rf_waddr,
        rdata1:   rdata1,
        rdata2:   rdata2
    };

endmodule

`default_nettype wire

/* sim/id_tasks.svh */
`ifndef ID_TASKS_SVH
`define ID_TASKS_SVH

task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
endtask

task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
        stop_run($sformatf("Fail %s exp %0h got %0h", name, exp, got));
    end
endtask

// instruction encoders
function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [4:0] sa,
                                      input logic [5:0] fn);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
endfunction

function automatic reg_write_t wr_bus(input logic we, input logic [4:0] addr,
                                      input logic [31:0] data);
    return {we, addr, data};
endfunction

task automatic fetch_pc(input logic [31:0] pc);
    @(posedge clk);
    if_to_id <= {1'b1, pc};
endtask

task automatic wait_decode(input logic [31:0] pc, input logic [31:0] instr);
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while ((id_to_ex.pc !== pc || id_to_ex.inst !== instr) && n < 8);
    if (id_to_ex.pc !== pc || id_to_ex.inst !== instr) begin
        stop_run($sformatf("instruction %0h at pc %0h never reached decode", instr, pc));
    end
endtask

// sync sram answers one cycle after the pc is taken
task automatic issue(input logic [31:0] pc, input logic [31:0] instr);
    fetch_pc(pc);
    @(posedge clk);
    inst_sram_rdata <= instr;
    wait_decode(pc, instr);
endtask

task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    wb_to_rf <= wr_bus(1'b1, addr, data);
    rval[addr] = data;
    @(posedge clk);
    wb_to_rf <= '0;
endtask

task automatic drive_fw(input reg_write_t ex, input reg_write_t mem, input reg_write_t wb,
                        input logic load);
    @(posedge clk);
    ex_fw      <= ex;
    mem_fw     <= mem;
    wb_fw      <= wb;
    ex_is_load <= load;
    @(negedge clk);
endtask

task automatic check_idle();
    check("rf_we", 0, id_to_ex.rf_we);
    check("mem_en", 0, id_to_ex.mem_en);
    check("mem_wen", 0, id_to_ex.mem_wen);
    check("br.taken", 0, br.taken);
    check("stallreq", 0, stallreq);
endtask

// alu one-hot bits from msb are add sub slt sltu and nor or xor sll srl sra lui
task automatic check_ctrl(input logic [11:0] alu, input logic [2:0] s1, input logic [3:0] s2,
                          input logic we, input logic [4:0] waddr, input logic men,
                          input logic [3:0] wen);
    check("alu_op", alu, id_to_ex.alu_op);
    check("src1_sel", s1, id_to_ex.src1_sel);
    check("src2_sel", s2, id_to_ex.src2_sel);
    check("rf_we", we, id_to_ex.rf_we);
    if (we) begin
        check("rf_waddr", waddr, id_to_ex.rf_waddr);
    end
    check("mem_en", men, id_to_ex.mem_en);
    check("mem_wen", wen, id_to_ex.mem_wen);
endtask

task automatic reset_and_bubble();
    @(negedge clk);
    check_idle();
    // a live jal would be taken and write r31
    fetch_pc(32'h0000_0040);
    @(posedge clk);
    inst_sram_rdata <= jtype(OP_JAL, 26'h10);
    stall <= STALL_W'(1 << STALL_IF); // IF stopped and ID running
    wait_decode(32'h0000_0040, jtype(OP_JAL, 26'h10));
    check("br.taken", 1, br.taken);
    @(negedge clk);
    check_idle(); // bubble now
    @(posedge clk);
    stall <= '0;
endtask

task automatic alu_decode();
    write_reg(5'd8, $urandom);
    write_reg(5'd9, $urandom);
    write_reg(5'd0, 32'hdead_beef); // must not stick
    issue(32'h100, rtype(5'd8, 5'd9, 5'd10, 5'd0, FN_ADDU));
    check_ctrl(12'h800, 3'b001, 4'b0001, 1'b1, 5'd10, 1'b0, 4'h0);
    check("rdata1", rval[8], id_to_ex.rdata1);
    check("rdata2", rval[9], id_to_ex.rdata2);
    issue(32'h104, itype(OP_ORI, 5'd8, 5'd11, 16'h5a5a));
    check_ctrl(12'h020, 3'b001, 4'b1000, 1'b1, 5'd11, 1'b0, 4'h0);
    check("rdata1", rval[8], id_to_ex.rdata1);
    issue(32'h108, rtype(5'd0, 5'd9, 5'd12, 5'd4, FN_SLL));
    check_ctrl(12'h008, 3'b100, 4'b0001, 1'b1, 5'd12, 1'b0, 4'h0);
    check("rdata1 r0", 0, id_to_ex.rdata1);
    check("rdata2", rval[9], id_to_ex.rdata2);
    issue(32'h10c, rtype(5'd8, 5'd9, 5'd13, 5'd0, FN_SLT));
    check_ctrl(12'h200, 3'b001, 4'b0001, 1'b1, 5'd13, 1'b0, 4'h0);
    issue(32'h110, itype(OP_LUI, 5'd0, 5'd14, 16'h1234));
    check_ctrl(12'h001, 3'b000, 4'b0010, 1'b1, 5'd14, 1'b0, 4'h0);
    issue(32'h114, itype(OP_LW, 5'd8, 5'd15, 16'h0004));
    check_ctrl(12'h800, 3'b001, 4'b0010, 1'b1, 5'd15, 1'b1, 4'h0);
    check("rdata1", rval[8], id_to_ex.rdata1);
    issue(32'h118, itype(OP_SW, 5'd8, 5'd9, 16'h0008));
    check_ctrl(12'h800, 3'b001, 4'b0010, 1'b0, 5'd0, 1'b1, 4'hf);
    check("rdata1", rval[8], id_to_ex.rdata1);
    check("rdata2", rval[9], id_to_ex.rdata2);
endtask

task automatic forward_priority();
    logic [31:0] a, b, c;
    a = $urandom;
    b = $urandom;
    c = $urandom;
    issue(32'h200, rtype(5'd8, 5'd9, 5'd10, 5'd0, FN_ADDU));
    drive_fw(wr_bus(1, 5'd8, a), wr_bus(1, 5'd8, b), wr_bus(1, 5'd8, c), 1'b0);
    check("rdata1 ex", a, id_to_ex.rdata1);
    drive_fw(wr_bus(0, 5'd8, a), wr_bus(1, 5'd8, b), wr_bus(1, 5'd8, c), 1'b0);
    check("rdata1 mem", b, id_to_ex.rdata1);
    drive_fw(wr_bus(0, 5'd8, a), wr_bus(0, 5'd8, b), wr_bus(1, 5'd8, c), 1'b0);
    check("rdata1 wb", c, id_to_ex.rdata1);
    drive_fw('0, '0, '0, 1'b0);
    check("rdata1 rf", rval[8], id_to_ex.rdata1);
    drive_fw('0, wr_bus(1, 5'd9, b), '0, 1'b0);
    check("rdata2 mem", b, id_to_ex.rdata2);
    // r0 target is never forwarded
    issue(32'h204, rtype(5'd0, 5'd9, 5'd10, 5'd0, FN_ADDU));
    drive_fw(wr_bus(1, 5'd0, a), wr_bus(1, 5'd0, b), wr_bus(1, 5'd0, c), 1'b0);
    check("rdata1 r0", 0, id_to_ex.rdata1);
    drive_fw('0, '0, '0, 1'b0);
endtask

task automatic load_use_stall();
    issue(32'h300, rtype(5'd8, 5'd9, 5'd10, 5'd0, FN_ADDU));
    drive_fw(wr_bus(1, 5'd8, 0), '0, '0, 1'b1);
    check("stallreq rs", 1, stallreq);
    drive_fw(wr_bus(1, 5'd9, 0), '0, '0, 1'b1);
    check("stallreq rt", 1, stallreq);
    drive_fw(wr_bus(1, 5'd12, 0), '0, '0, 1'b1);
    check("stallreq other", 0, stallreq);
    drive_fw(wr_bus(1, 5'd8, 0), '0, '0, 1'b0);
    check("stallreq no load", 0, stallreq);
    issue(32'h304, itype(OP_ORI, 5'd8, 5'd11, 16'h00ff)); // rt is only a target
    drive_fw(wr_bus(1, 5'd11, 0), '0, '0, 1'b1);
    check("stallreq ori rt", 0, stallreq);
    drive_fw(wr_bus(1, 5'd8, 0), '0, '0, 1'b1);
    check("stallreq ori rs", 1, stallreq);
    issue(32'h308, rtype(5'd0, 5'd9, 5'd10, 5'd0, FN_ADDU));
    drive_fw(wr_bus(1, 5'd0, 0), '0, '0, 1'b1);
    check("stallreq r0", 0, stallreq);
    issue(32'h30c, jtype(OP_JAL, {5'd8, 5'd9, 16'h0000}));
    drive_fw(wr_bus(1, 5'd8, 0), '0, '0, 1'b1);
    check("stallreq jal", 0, stallreq);
    drive_fw('0, '0, '0, 1'b0);
endtask

task automatic branch_case(input logic [31:0] pc, input logic [31:0] instr,
                           input logic taken, input logic [31:0] target);
    issue(pc, instr);
    check("br.taken", taken, br.taken);
    if (taken) begin
        check("br.target", target, br.target);
    end
endtask

task automatic branch_resolve();
    logic [31:0] pos;
    pos = ($urandom >> 1) | 32'd1;
    write_reg(5'd1, pos);
    write_reg(5'd2, pos);
    write_reg(5'd3, $urandom | 32'h8000_0000); // negative
    write_reg(5'd4, pos + 32'd1);
    branch_case(32'h0040_0000, itype(OP_BEQ, 5'd1, 5'd2, 16'h0010), 1, 32'h0040_0044);
    branch_case(32'h0040_0010, itype(OP_BEQ, 5'd1, 5'd4, 16'h0010), 0, 0);
    branch_case(32'h0040_0100, itype(OP_BNE, 5'd1, 5'd4, 16'hfff0), 1, 32'h0040_00c4);
    branch_case(32'h0040_0110, itype(OP_BNE, 5'd1, 5'd2, 16'h0010), 0, 0);
    branch_case(32'h0040_0200, itype(OP_REGIMM, 5'd1, RT_BGEZ, 16'h0008), 1, 32'h0040_0224);
    branch_case(32'h0040_0210, itype(OP_REGIMM, 5'd3, RT_BGEZ, 16'h0008), 0, 0);
    branch_case(32'h0040_0300, itype(OP_REGIMM, 5'd3, RT_BLTZ, 16'h0100), 1, 32'h0040_0704);
    branch_case(32'h0040_0310, itype(OP_REGIMM, 5'd1, RT_BLTZ, 16'h0100), 0, 0);
    branch_case(32'h0040_0400, itype(OP_BGTZ, 5'd0, 5'd0, 16'h0001), 0, 0);
    branch_case(32'h0040_0410, itype(OP_BLEZ, 5'd0, 5'd0, 16'h0001), 1, 32'h0040_0418);
    branch_case(32'h0040_0420, itype(OP_BGTZ, 5'd1, 5'd0, 16'h0002), 1, 32'h0040_042c);
    branch_case(32'hbfc0_0000, jtype(OP_J, 26'h012_3456), 1, 32'hb048_d158);
    branch_case(32'h2fff_fffc, jtype(OP_J, 26'h3ff_ffff), 1, 32'h3fff_fffc); // pc+4 region
    branch_case(32'h0040_0500, rtype(5'd1, 5'd0, 5'd0, 5'd0, FN_JR), 1, pos);
    branch_case(32'h8000_0010, jtype(OP_JAL, 26'h000_0040), 1, 32'h8000_0100);
    check("rf_we jal", 1, id_to_ex.rf_we);
    check("rf_waddr jal", 31, id_to_ex.rf_waddr);
endtask

task automatic stall_hold();
    logic [31:0] held, next;
    held = itype(OP_ADDIU, 5'd8, 5'd20, 16'h7777);
    next = rtype(5'd8, 5'd9, 5'd21, 5'd0, FN_ADDU);
    fetch_pc(32'h0000_0600);
    @(posedge clk);
    inst_sram_rdata <= held;
    stall           <= STALL_W'((1 << STALL_IF) | (1 << STALL_ID));
    if_to_id        <= {1'b1, 32'h0000_0604};
    wait_decode(32'h0000_0600, held);
    repeat (4) begin
        @(posedge clk);
        inst_sram_rdata <= $urandom; // junk while stalled
        @(negedge clk);
        check("id_to_ex.pc", 32'h0000_0600, id_to_ex.pc);
        check("id_to_ex.inst", held, id_to_ex.inst);
    end
    @(posedge clk);
    stall <= '0;
    @(posedge clk);
    inst_sram_rdata <= next;
    wait_decode(32'h0000_0604, next);
    check("rf_waddr", 21, id_to_ex.rf_waddr);
endtask

`endif

/* sim/tb_id_stage.sv */
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    logic               clk = 1'b0;
    logic               rst;
    logic [STALL_W-1:0] stall;
    if_to_id_t          if_to_id;
    logic [XLEN-1:0]    inst_sram_rdata;
    reg_write_t         wb_to_rf;
    reg_write_t         ex_fw;
    reg_write_t         mem_fw;
    reg_write_t         wb_fw;
    logic               ex_is_load;
    id_to_ex_t          id_to_ex;
    br_t                br;
    logic               stallreq;

    logic [XLEN-1:0] rval [32]; // what the tb has written to each register

    always #10 clk = ~clk;

    id_stage u_id_stage (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .if_to_id        (if_to_id),
        .inst_sram_rdata (inst_sram_rdata),
        .wb_to_rf        (wb_to_rf),
        .ex_fw           (ex_fw),
        .mem_fw          (mem_fw),
        .wb_fw           (wb_fw),
        .ex_is_load      (ex_is_load),
        .id_to_ex        (id_to_ex),
        .br              (br),
        .stallreq        (stallreq)
    );

    `include "id_tasks.svh"

    initial begin
        void'($urandom(32'hab6f_5e62));
        rst             = 1'b1;
        stall           = '0;
        if_to_id        = '0;
        inst_sram_rdata = '0;
        wb_to_rf        = '0;
        ex_fw           = '0;
        mem_fw          = '0;
        wb_fw           = '0;
        ex_is_load      = 1'b0;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        reset_and_bubble();
        alu_decode();
        forward_priority();
        load_use_stall();
        branch_resolve();
        stall_hold();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+sim
design/id_pkg.sv
design/if_id_reg.sv
design/regfile.sv
design/inst_decoder.sv
design/operand_forward.sv
design/branch_unit.sv
design/id_stage.sv
sim/tb_id_stage.sv

/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_id_stage -o tb_id_stage
	./obj_dir/tb_id_stage > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
